//--- axi_wr_master.f
+incdir+logic
logic/axi_wr_pkg.sv
logic/lfsr32.sv
logic/wr_issue.sv
logic/wr_ostd_slot.sv
logic/wr_resp_check.sv
logic/axi_wr_master.sv
verif/tb_axi_wr_master.sv

//--- run_sim.sh
#!/bin/sh
# Builds the write master testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_axi_wr_master \
    -f axi_wr_master.f \
    -o tb_axi_wr_master || { echo "Verilator build failed"; exit 1; }

result=$(./obj_dir/tb_axi_wr_master)
echo "$result"
echo "$result" | grep -qx "TEST OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- verif/tb_axi_wr_master.sv
/* Directed testbench for the AXI4-lite write master, with a slave model that answers out of order.
   Random ready and delay values come from an xorshift generator with a fixed seed. */

`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_settings.svh"

module tb_axi_wr_master import axi_wr_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam logic [31:0] RNG_SEED = 32'h150c_3f58;
    // Cycle budget of the six tests plus a margin
    localparam int RUN_CYCLES = 100 + 40 * 20 + 450 + 60 * 20 + 200 + 200
                              + (`OR_TIMEOUT + 150) + 2000;

    logic                   aclk;
    logic                   aresetn;
    logic                   en;
    logic [`AXI_ADDR_W-1:0] addr_min;
    logic [`AXI_ADDR_W-1:0] addr_max;
    aw_req_t                aw_req;
    logic                   awvalid;
    logic                   wvalid;
    logic                   awready = 1'b0;
    logic                   wready = 1'b0;
    logic                   bvalid;
    b_rsp_t                 b_rsp;
    logic                   bready;
    err_flags_t             err;

    logic [31:0] ready_rng = ~RNG_SEED;
    logic [31:0] resp_rng;
    aw_req_t     pending[$];
    int          issued_at[$];
    aw_req_t     held;
    logic        held_ok = 1'b0;
    slot_idx_t   next_slot = '0;
    int          cycle = 0;
    int          accepts = 0;
    int          errors;
    int          checks;

    axi_wr_master uut (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .en       (en),
        .addr_min (addr_min),
        .addr_max (addr_max),
        .aw_req   (aw_req),
        .awvalid  (awvalid),
        .wvalid   (wvalid),
        .awready  (awready),
        .wready   (wready),
        .bvalid   (bvalid),
        .b_rsp    (b_rsp),
        .bready   (bready),
        .err      (err)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        resp_rng = xorshift(resp_rng);
        return int'(resp_rng % 32'(n));
    endfunction

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Mismatch at %0t: %s", $time, what);
        end
    endtask

    task automatic expect_done(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("Timed out at %0t while waiting for %s", $time, what);
        end
    endtask

    task automatic apply_reset();
        @(negedge aclk);
        aresetn = 1'b0;
        bvalid  = 1'b0;
        repeat (5) @(negedge aclk);
        aresetn = 1'b1;
    endtask

    task automatic wait_accepts(input int target, input int limit);
        int n;
        n = 0;
        while (accepts < target && n < limit) begin
            @(negedge aclk);
            n++;
        end
        expect_done(accepts >= target, "write accepts");
    endtask

    // Drive one B beat from a falling edge until bready takes it
    task automatic send_beat(input logic [`AXI_ID_W-1:0] id, input logic [1:0] resp);
        int waited;
        @(negedge aclk);
        bvalid     = 1'b1;
        b_rsp.id   = id;
        b_rsp.resp = resp;
        waited = 0;
        while (!bready && waited < 200) begin
            @(negedge aclk);
            waited++;
        end
        expect_done(bready, "bready");
        @(negedge aclk);
        bvalid = 1'b0;
    endtask

    task automatic return_response(input logic corrupt);
        int      idx;
        aw_req_t req;
        idx = rand_below(pending.size());
        // Oldest write goes first once it has waited half the timeout
        if (cycle - issued_at[0] > `OR_TIMEOUT / 2) begin
            idx = 0;
        end
        req = pending[idx];
        pending.delete(idx);
        issued_at.delete(idx);
        repeat (rand_below(6)) @(negedge aclk);
        send_beat(req.id, corrupt ? (req.addr[3:2] ^ 2'b01) : req.addr[3:2]);
    endtask

    task automatic answer_responses(input int count, input logic corrupt);
        int start;
        int done;
        start = cycle;
        done = 0;
        while (done < count && cycle - start < count * 40) begin
            if (pending.size() > 0) begin
                return_response(corrupt);
                done++;
            end else begin
                @(negedge aclk);
            end
        end
        expect_done(done == count, "B responses");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Slave model, ready pacing and channel monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge aclk) begin
        ready_rng = xorshift(ready_rng);
        awready = ready_rng[1:0] != 2'b00;
        wready  = ready_rng[3:2] != 2'b00;
    end

    always @(posedge aclk) begin
        cycle++;
        if (!aresetn) begin
            pending.delete();
            issued_at.delete();
            next_slot = '0;
            held_ok = 1'b0;
        end else begin
            expect_true(awvalid == wvalid, "awvalid and wvalid differ");
            if (held_ok) begin
                expect_true(awvalid && aw_req == held, "request dropped or changed while waiting");
            end
            if (awvalid && awready && wready) begin
                expect_true(aw_req.addr[1:0] == 2'b00
                            && aw_req.addr >= {addr_min[`AXI_ADDR_W-1:2], 2'b00}
                            && aw_req.addr <= addr_max,
                            $sformatf("address %h unaligned or outside window", aw_req.addr));
                expect_true(aw_req.id == `MST_ID + `AXI_ID_W'(next_slot),
                            $sformatf("ID %h out of order", aw_req.id));
                expect_true(aw_req.strb == '1, "write strobes not all set");
                pending.push_back(aw_req);
                issued_at.push_back(cycle);
                accepts++;
                next_slot++;
            end
            held_ok = awvalid && !(awready && wready);
            held = aw_req;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_and_enable();
        logic rose;
        en = 1'b0;
        apply_reset();
        expect_true(!awvalid && !wvalid && !bready, "valid or bready high after reset");
        expect_true(err == '0, "error flags not clear after reset");
        rose = 1'b0;
        repeat (50) begin
            @(negedge aclk);
            rose = rose | awvalid;
        end
        expect_true(!rose, "awvalid rose with en low");
    endtask

    task automatic address_rules();
        addr_min = 8'h45;
        addr_max = 8'h9E;
        en = 1'b1;
        answer_responses(40, 1'b0);
    endtask

    task automatic id_order_and_limit();
        int   start;
        logic rose;
        apply_reset();
        start = accepts;
        wait_accepts(start + `OSTD_NUM, 400);
        for (int i = 0; i < pending.size(); i++) begin
            expect_true(pending[i].id == `MST_ID + `AXI_ID_W'(i),
                        $sformatf("write %0d carries ID %h", i, pending[i].id));
        end
        rose = 1'b0;
        repeat (50) begin
            @(negedge aclk);
            rose = rose | awvalid;
        end
        expect_true(!rose, "awvalid rose with every slot busy");
        expect_true(accepts - start == `OSTD_NUM,
                    $sformatf("%0d writes accepted without responses", accepts - start));
    endtask

    task automatic correct_traffic();
        // Slots held by the limit test are close to the timeout
        apply_reset();
        answer_responses(60, 1'b0);
        wait_accepts(accepts + 1, 200);
        expect_true(err == '0, "error flag set by correct responses");
    endtask

    task automatic response_errors();
        answer_responses(1, 1'b1);
        expect_true(err.resp_mismatch && !err.unknown_bid, "wrong BRESP not flagged");
        en = 1'b0;
        apply_reset();
        // Slot 0 still holds this ID from earlier traffic but is no longer busy
        send_beat(`MST_ID, 2'b00);
        expect_true(err.unknown_bid && !err.resp_mismatch, "stray BID not flagged");
    endtask

    task automatic timeout_flag();
        apply_reset();
        en = 1'b1;
        wait_accepts(accepts + 1, 200);
        expect_true(err == '0, "error flag set before the timeout");
        repeat (`OR_TIMEOUT + 6) @(negedge aclk);
        expect_true(err.ostd_timeout, "held response did not set ostd_timeout");
        en = 1'b0;
        repeat (20) @(negedge aclk);
        answer_responses(pending.size(), 1'b0);
        repeat (10) @(negedge aclk);
        expect_true(err.ostd_timeout && !err.resp_mismatch && !err.unknown_bid,
                    "ostd_timeout did not stay set");
    endtask

    initial begin
        aclk     = 1'b0;
        aresetn  = 1'b0;
        en       = 1'b0;
        addr_min = 8'h10;
        addr_max = 8'hEF;
        bvalid   = 1'b0;
        b_rsp    = '0;
        resp_rng = RNG_SEED;
        errors   = 0;
        checks   = 0;
        reset_and_enable();
        address_rules();
        id_order_and_limit();
        correct_traffic();
        response_errors();
        timeout_flag();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("The run timed out after %0d cycles before the tests finished", RUN_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/axi_wr_master.sv
/* AXI4-lite random write master, single-beat writes only, no read channels.
   AW and W always travel together and are accepted on the same edge. */

`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_settings.svh"

module axi_wr_master import axi_wr_pkg::*; (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   en,
    input  logic [`AXI_ADDR_W-1:0] addr_min,
    input  logic [`AXI_ADDR_W-1:0] addr_max,
    output aw_req_t                aw_req,
    output logic                   awvalid,
    output logic                   wvalid,
    input  logic                   awready,
    input  logic                   wready,
    input  logic                   bvalid,
    input  b_rsp_t                 b_rsp,
    output logic                   bready,
    output err_flags_t             err
);

    ostd_entry_t                  load_entry;
    ostd_entry_t [`OSTD_NUM-1:0]  entries;
    logic [`OSTD_NUM-1:0]         load;
    logic [`OSTD_NUM-1:0]         free;
    logic [`OSTD_NUM-1:0]         slot_busy;
    logic [`OSTD_NUM-1:0]         slot_timeout;

    wr_issue u_issue (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .en        (en),
        .addr_min  (addr_min),
        .addr_max  (addr_max),
        .slot_busy (slot_busy),
        .awready   (awready),
        .wready    (wready),
        .awvalid   (awvalid),
        .wvalid    (wvalid),
        .aw_req    (aw_req),
        .load      (load),
        .entry     (load_entry)
    );

    // One slot per outstanding write
    for (genvar i = 0; i < `OSTD_NUM; i++) begin : g_slot
        wr_ostd_slot u_slot (
            .aclk     (aclk),
            .aresetn  (aresetn),
            .load     (load[i]),
            .free     (free[i]),
            .entry_in (load_entry),
            .entry    (entries[i]),
            .timeout  (slot_timeout[i])
        );

        assign slot_busy[i] = entries[i].busy;
    end

    wr_resp_check u_check (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .bvalid       (bvalid),
        .b_rsp        (b_rsp),
        .bready       (bready),
        .entries      (entries),
        .slot_timeout (slot_timeout),
        .free         (free),
        .err          (err)
    );

endmodule

`default_nettype wire

//--- logic/wr_resp_check.sv
/* Drains B responses into the slots and keeps sticky error flags.
   Flags clear only on aresetn. */

`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_settings.svh"

module wr_resp_check import axi_wr_pkg::*; (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           bvalid,
    input  b_rsp_t                         b_rsp,
    output logic                           bready,
    input  ostd_entry_t [`OSTD_NUM-1:0]    entries,
    input  logic [`OSTD_NUM-1:0]           slot_timeout,
    output logic [`OSTD_NUM-1:0]           free,
    output err_flags_t                     err
);

    localparam int N = `OSTD_NUM;

    logic [31:0]  rdy_lfsr;
    logic [31:0]  rdy_sr;
    logic         rdy_reload;
    logic         hs;
    logic [N-1:0] hit;
    logic [1:0]   hit_exp;

    //////////////////////////////////////////////////////////////////////
    // BREADY pacing
    //////////////////////////////////////////////////////////////////////

    assign bready     = rdy_sr[0];
    assign rdy_reload = (rdy_sr == 32'h0) | bready;

    lfsr32 u_rdy_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (rdy_reload),
        .lfsr    (rdy_lfsr)
    );

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rdy_sr <= 32'h0;
        end else if (rdy_reload) begin
            rdy_sr <= rdy_lfsr;
        end else begin
            rdy_sr <= rdy_sr >> 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // BID lookup and flags
    //////////////////////////////////////////////////////////////////////

    // Slot IDs are unique, so at most one bit of hit is set
    always_comb begin
        hit     = '0;
        hit_exp = 2'b00;
        for (int i = 0; i < N; i++) begin
            if (entries[i].busy && entries[i].id == b_rsp.id) begin
                hit[i]  = 1'b1;
                hit_exp = hit_exp | entries[i].exp_resp;
            end
        end
    end

    assign hs   = bvalid & bready;
    assign free = {N{hs}} & hit;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            err <= '0;
        end else begin
            if (hs && |hit && hit_exp != b_rsp.resp) begin
                err.resp_mismatch <= 1'b1;
            end
            if (hs && !(|hit)) begin
                err.unknown_bid <= 1'b1;
            end
            if (|slot_timeout) begin
                err.ostd_timeout <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/wr_ostd_slot.sv
/* One outstanding-write slot. load and free never hit the same slot in one cycle. */

`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_settings.svh"

module wr_ostd_slot import axi_wr_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        load,
    input  logic        free,
    input  ostd_entry_t entry_in,
    output ostd_entry_t entry,
    output logic        timeout
);

    localparam int LIMIT = `OR_TIMEOUT;
    localparam int AGE_W = $clog2(LIMIT + 2);

    logic                 busy;
    logic [`AXI_ID_W-1:0] id_q;
    logic [1:0]           exp_q;
    logic [AGE_W-1:0]     age;

    // Busy flag and age, age saturates one past the limit
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy    <= 1'b0;
            age     <= '0;
            timeout <= 1'b0;
        end else begin
            if (load) begin
                busy <= entry_in.busy;
                age  <= '0;
            end else if (free) begin
                busy <= 1'b0;
                age  <= '0;
            end else if (busy && age <= AGE_W'(LIMIT)) begin
                age <= age + 1'b1;
            end
            timeout <= busy & ~free & (age == AGE_W'(LIMIT));
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            id_q  <= entry_in.id;
            exp_q <= entry_in.exp_resp;
        end
    end

    always_comb begin
        entry.busy     = busy;
        entry.id       = id_q;
        entry.exp_resp = exp_q;
    end

endmodule

`default_nettype wire

//--- logic/wr_issue.sv
/* Issues single-beat AW+W writes with random pacing, address clamped to [addr_min, addr_max].
   addr_min and addr_max must stay stable while a request is pending. */

`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_settings.svh"

module wr_issue import axi_wr_pkg::*; (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   en,
    input  logic [`AXI_ADDR_W-1:0] addr_min,
    input  logic [`AXI_ADDR_W-1:0] addr_max,
    input  logic [`OSTD_NUM-1:0]   slot_busy,
    input  logic                   awready,
    input  logic                   wready,
    output logic                   awvalid,
    output logic                   wvalid,
    output aw_req_t                aw_req,
    output logic [`OSTD_NUM-1:0]   load,
    output ostd_entry_t            entry
);

    localparam int ID_W   = `AXI_ID_W;
    localparam int ADDR_W = `AXI_ADDR_W;
    localparam int DATA_W = `AXI_DATA_W;
    localparam int N      = `OSTD_NUM;

    logic [31:0]       pay_lfsr;
    logic [31:0]       pace_lfsr;
    logic [31:0]       pace_sr;
    logic              valid;
    logic              accept;
    logic              pace_reload;
    slot_idx_t         cnt;
    logic [ADDR_W-1:0] raw_addr;
    logic [ADDR_W-1:0] clamp_addr;

    assign accept      = valid & awready & wready;
    assign pace_reload = (pace_sr == 32'h0) | accept;

    // Payload only moves on accept, so the beat stays frozen under back-pressure
    lfsr32 u_pay_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (accept),
        .lfsr    (pay_lfsr)
    );

    lfsr32 u_pace_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (pace_reload),
        .lfsr    (pace_lfsr)
    );

    //////////////////////////////////////////////////////////////////////
    // Pacing and valid
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pace_sr <= 32'h0;
        end else if (pace_reload) begin
            pace_sr <= pace_lfsr;
        end else if (!valid && en) begin
            pace_sr <= pace_sr >> 1;
        end
    end

    // Once raised, valid only drops on accept
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid <= 1'b0;
        end else if (accept) begin
            valid <= 1'b0;
        end else if (!valid && en && !slot_busy[cnt] && pace_sr[0]) begin
            valid <= 1'b1;
        end
    end

    assign awvalid = valid;
    assign wvalid  = valid;

    // Slot counter, also the low part of the ID
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cnt <= '0;
        end else if (accept) begin
            cnt <= (cnt == slot_idx_t'(N - 1)) ? '0 : cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Beat contents
    //////////////////////////////////////////////////////////////////////

    assign raw_addr   = pay_lfsr[ADDR_W-1:0];
    assign clamp_addr = (raw_addr > addr_max) ? addr_max :
                        (raw_addr < addr_min) ? addr_min : raw_addr;

    always_comb begin
        aw_req.id   = `MST_ID + ID_W'(cnt);
        aw_req.addr = {clamp_addr[ADDR_W-1:2], 2'b00};
        aw_req.data = pay_lfsr[DATA_W-1:0];
        aw_req.strb = '1;
    end

    // Slot write on accept, expected BRESP is addr[3:2]
    assign load = {N{accept}} & (N'(1) << cnt);

    always_comb begin
        entry.busy     = 1'b1;
        entry.id       = aw_req.id;
        entry.exp_resp = aw_req.addr[3:2];
    end

endmodule

`default_nettype wire

//--- logic/lfsr32.sv
/* 32-bit Galois LFSR, x^32 + x^22 + x^2 + x + 1. Holds its value while en is low. */

`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_settings.svh"

module lfsr32 (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        en,
    output logic [31:0] lfsr
);

    localparam logic [31:0] TAPS = 32'h8020_0003;

    logic [31:0] lfsr_next;

    // Right shift, taps folded in when bit 0 falls out
    assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ TAPS) : (lfsr >> 1);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lfsr <= `LFSR_KEY;
        end else if (en) begin
            lfsr <= lfsr_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_wr_pkg.sv
/* Types shared by the write master blocks.
   Field widths follow the macros of the settings header. */

`default_nettype none

`include "axi_wr_settings.svh"

package axi_wr_pkg;

    // AW and W beat, sent together as one single-beat write
    typedef struct packed {
        logic [`AXI_ID_W-1:0]     id;
        logic [`AXI_ADDR_W-1:0]   addr;
        logic [`AXI_DATA_W-1:0]   data;
        logic [`AXI_DATA_W/8-1:0] strb;
    } aw_req_t;

    // B beat
    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        logic [1:0]           resp;
    } b_rsp_t;

    // Content of one outstanding-write slot
    typedef struct packed {
        logic                 busy;
        logic [`AXI_ID_W-1:0] id;
        logic [1:0]           exp_resp;
    } ostd_entry_t;

    // Sticky checker flags
    typedef struct packed {
        logic resp_mismatch;
        logic unknown_bid;
        logic ostd_timeout;
    } err_flags_t;

    typedef logic [$clog2(`OSTD_NUM)-1:0] slot_idx_t;

endpackage

`default_nettype wire

//--- logic/axi_wr_settings.svh
/* Build settings for the AXI4-lite write traffic master.
   OR_TIMEOUT is counted in aclk cycles and LFSR_KEY must be nonzero. */

`ifndef AXI_WR_SETTINGS_SVH
`define AXI_WR_SETTINGS_SVH

// Bus widths
`define AXI_ADDR_W 8
`define AXI_ID_W 4
`define AXI_DATA_W 32

// Base ID, slot numbers are added on top
`define MST_ID 4'h8

// Outstanding writes in flight at most
`define OSTD_NUM 4

// Age in cycles after which a pending write is flagged
`define OR_TIMEOUT 100

// Seed of every LFSR in the design
`define LFSR_KEY 32'hFFFF_FFFF

`endif
